//--- src/rvPkg.sv
package rvPkg;

    localparam int xlen     = 32;
    localparam int regAddrW = 5;
    localparam int apbAddrW = 16;

    typedef enum logic [6:0] {
        LOAD   = 7'b0000011,
        OPIMM  = 7'b0010011,
        STORE  = 7'b0100011,
        BRANCH = 7'b1100011,
        OP     = 7'b0110011,
        SYSTEM = 7'b1110011
    } opcodeE;

    typedef enum logic [3:0] {
        ADD,
        SUB,
        AND,
        OR,
        SLL,
        SRL,
        SRA,
        EQ,
        NE
    } aluOpE;

    typedef enum logic [2:0] {
        IDLE,
        FETCH,
        EXECUTE,
        MEMORY,
        WRITEBACK,
        HALTED
    } cpuStateE;

    // APB map, region in pAddr[13:12]
    typedef enum logic [1:0] {
        IMEM = 2'd0,
        DMEM = 2'd1,
        REGS = 2'd2,   // read only
        CTRL = 2'd3
    } regionE;

    localparam logic [11:0] ctrlStartOff = 12'h000;
    localparam logic [11:0] ctrlPcOff    = 12'h004;

endpackage

//--- src/aluUnit.sv
`timescale 1ns/10ps

module aluUnit (
    input  rvPkg::aluOpE           aluOp,
    input  logic [rvPkg::xlen-1:0] opA,
    input  logic [rvPkg::xlen-1:0] opB,
    output logic [rvPkg::xlen-1:0] aluResult,
    output logic                   cond
);
    import rvPkg::*;

    logic [4:0] shamt;
    logic       equal;

    assign shamt = opB[4:0];
    assign equal = (opA == opB);

    always_comb begin
        case (aluOp)
            ADD:     aluResult = opA + opB;
            SUB:     aluResult = opA - opB;
            AND:     aluResult = opA & opB;
            OR:      aluResult = opA | opB;
            SLL:     aluResult = opA << shamt;
            SRL:     aluResult = opA >> shamt;
            SRA:     aluResult = $unsigned($signed(opA) >>> shamt);
            EQ, NE:  aluResult = opA - opB;
            default: aluResult = '0;
        endcase
    end

    // Branch condition
    always_comb begin
        case (aluOp)
            EQ:      cond = equal;
            NE:      cond = !equal;
            default: cond = 1'b0;
        endcase
    end

endmodule

//--- src/regFile.sv
`timescale 1ns/10ps

module regFile (
    input  logic                       clock,
    input  logic                       regWriteEn,
    input  logic [rvPkg::regAddrW-1:0] rs1,
    input  logic [rvPkg::regAddrW-1:0] rs2,
    input  logic [rvPkg::regAddrW-1:0] rd,
    input  logic [rvPkg::xlen-1:0]     wData,
    input  logic [rvPkg::regAddrW-1:0] dbgAddr,
    output logic [rvPkg::xlen-1:0]     rData1,
    output logic [rvPkg::xlen-1:0]     rData2,
    output logic [rvPkg::xlen-1:0]     dbgData
);
    import rvPkg::*;

    logic [xlen-1:0] regs [2**regAddrW];

    always_ff @(posedge clock) begin
        if (regWriteEn && (rd != '0))
            regs[rd] <= wData;
    end

    // x0 always reads zero
    assign rData1  = (rs1 == '0) ? '0 : regs[rs1];
    assign rData2  = (rs2 == '0) ? '0 : regs[rs2];
    assign dbgData = (dbgAddr == '0) ? '0 : regs[dbgAddr];

endmodule

//--- src/instrDecoder.sv
`timescale 1ns/10ps

module instrDecoder (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       instrLoad,
    input  logic [rvPkg::xlen-1:0]     instrIn,
    output rvPkg::opcodeE              opcode,
    output rvPkg::aluOpE               aluOp,
    output logic [rvPkg::xlen-1:0]     imm,
    output logic                       useImm,
    output logic [rvPkg::regAddrW-1:0] rs1,
    output logic [rvPkg::regAddrW-1:0] rs2,
    output logic [rvPkg::regAddrW-1:0] rd
);
    import rvPkg::*;

    logic [xlen-1:0] instr;
    logic [2:0]      funct3;
    logic            funct7b5;

    // Instruction register, loaded at the end of FETCH
    always_ff @(posedge clock) begin
        if (rst)
            instr <= '0;
        else if (instrLoad)
            instr <= instrIn;
    end

    assign opcode   = opcodeE'(instr[6:0]);
    assign funct3   = instr[14:12];
    assign funct7b5 = instr[30];
    assign rs1      = instr[19:15];
    assign rs2      = instr[24:20];
    assign rd       = instr[11:7];
    assign useImm   = opcode inside {LOAD, OPIMM, STORE};

    always_comb begin
        case (opcode)
            LOAD, OPIMM: imm = {{20{instr[31]}}, instr[31:20]};
            STORE:       imm = {{20{instr[31]}}, instr[31:25], instr[11:7]};
            BRANCH: begin
                imm = {{19{instr[31]}}, instr[31], instr[7], instr[30:25],
                       instr[11:8], 1'b0};
            end
            default:     imm = '0;
        endcase
    end

    always_comb begin
        case (opcode)
            OP, OPIMM: begin
                case (funct3)
                    3'b000:  aluOp = (opcode == OP && funct7b5) ? SUB : ADD;
                    3'b001:  aluOp = SLL;
                    3'b101:  aluOp = funct7b5 ? SRA : SRL;
                    3'b110:  aluOp = OR;
                    3'b111:  aluOp = AND;
                    default: aluOp = ADD;
                endcase
            end
            BRANCH:  aluOp = funct3[0] ? NE : EQ;
            default: aluOp = ADD;   // Address add for lw and sw
        endcase
    end

endmodule

//--- src/programCounter.sv
`timescale 1ns/10ps

module programCounter #(
    parameter int imemWords = 256
) (
    input  logic                   clock,
    input  logic                   rst,
    input  logic                   pcRestart,
    input  logic                   pcAdvance,
    input  logic                   pcBranch,
    input  logic                   cond,
    input  logic [rvPkg::xlen-1:0] imm,
    output logic [rvPkg::xlen-1:0] pc
);
    import rvPkg::*;

    localparam int spanW = $clog2(imemWords) + 2;   // Byte address bits of IMEM

    logic [xlen-1:0] offset;
    logic [xlen-1:0] pcSum;

    assign offset = (pcBranch && cond) ? imm : xlen'(4);
    assign pcSum  = pc + offset;

    always_ff @(posedge clock) begin
        if (rst)
            pc <= '0;
        else if (pcRestart)
            pc <= '0;
        else if (pcAdvance || pcBranch)
            pc <= {{(xlen-spanW){1'b0}}, pcSum[spanW-1:0]};   // Wrap inside IMEM
    end

endmodule

//--- src/memSystem.sv
`timescale 1ns/10ps

module memSystem #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic                       clock,
    input  logic                       apbOwnsMem,
    input  logic                       pWrite,
    input  logic                       pSel,
    input  logic                       pEnable,
    input  logic [rvPkg::apbAddrW-1:0] pAddr,
    input  logic [rvPkg::xlen-1:0]     pWData,
    input  logic [rvPkg::xlen-1:0]     pc,
    input  logic                       instrLoad,
    input  logic                       dmemWriteEn,
    input  logic [rvPkg::xlen-1:0]     dAddr,
    input  logic [rvPkg::xlen-1:0]     dWData,
    output logic [rvPkg::xlen-1:0]     instrOut,
    output logic [rvPkg::xlen-1:0]     dRData,
    output logic [rvPkg::xlen-1:0]     memRData
);
    import rvPkg::*;

    localparam int iIdxW = $clog2(imemWords);
    localparam int dIdxW = $clog2(dmemWords);

    logic [xlen-1:0]  imem [imemWords];
    logic [xlen-1:0]  dmem [dmemWords];
    logic [iIdxW-1:0] iApbIdx;
    logic [iIdxW-1:0] imemIdx;
    logic [dIdxW-1:0] dApbIdx;
    logic [dIdxW-1:0] dCoreIdx;
    logic [xlen-1:0]  imemRd;
    logic             apbWrite;
    logic             toDmem;

    assign toDmem   = (regionE'(pAddr[13:12]) == DMEM);
    assign apbWrite = apbOwnsMem && pSel && pEnable && pWrite;
    assign iApbIdx  = pAddr[iIdxW+1:2];
    assign dApbIdx  = pAddr[dIdxW+1:2];
    assign dCoreIdx = dAddr[dIdxW+1:2];

    ////////////////////////////////////////
    // Instruction RAM
    ////////////////////////////////////////
    // Fetch and APB share one read port
    assign imemIdx  = instrLoad ? pc[iIdxW+1:2] : iApbIdx;
    assign imemRd   = imem[imemIdx];
    assign instrOut = imemRd;

    always_ff @(posedge clock) begin
        if (apbWrite && !toDmem)
            imem[iApbIdx] <= pWData;
    end

    ////////////////////////////////////////
    // Data RAM
    ////////////////////////////////////////
    always_ff @(posedge clock) begin
        if (apbWrite && toDmem)
            dmem[dApbIdx] <= pWData;
        else if (dmemWriteEn)
            dmem[dCoreIdx] <= dWData;
        dRData <= dmem[dCoreIdx];   // Held for WRITEBACK of lw
    end

    assign memRData = toDmem ? dmem[dApbIdx] : imemRd;

endmodule

//--- src/cycleSequencer.sv
`timescale 1ns/10ps

module cycleSequencer (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       pSel,
    input  logic                       pEnable,
    input  logic                       pWrite,
    input  logic [rvPkg::apbAddrW-1:0] pAddr,
    input  logic [rvPkg::xlen-1:0]     pWData,
    input  rvPkg::opcodeE              opcode,
    input  logic [rvPkg::xlen-1:0]     pc,
    input  logic                       cond,
    input  logic [rvPkg::xlen-1:0]     memRData,
    input  logic [rvPkg::xlen-1:0]     dbgData,
    output logic                       pReady,
    output logic [rvPkg::xlen-1:0]     ctrlRData,
    output logic                       instrLoad,
    output logic                       pcRestart,
    output logic                       pcAdvance,
    output logic                       pcBranch,
    output logic                       regWriteEn,
    output logic                       dmemWriteEn,
    output logic                       apbOwnsMem,
    output rvPkg::cpuStateE            state
);
    import rvPkg::*;

    cpuStateE    nextState;
    regionE      region;
    logic [11:0] offset;
    logic        running;
    logic        halted;
    logic        startReq;
    logic        branchStep;
    logic        retire;

    assign region  = regionE'(pAddr[13:12]);
    assign offset  = pAddr[11:0];
    assign running = (state != IDLE) && (state != HALTED);
    assign halted  = (state == HALTED);

    ////////////////////////////////////////
    // APB side
    ////////////////////////////////////////
    assign pReady     = (region == CTRL) || !running;   // RAMs and regs wait for halt
    assign apbOwnsMem = !running && ((region == IMEM) || (region == DMEM));
    assign startReq   = pSel && pEnable && pWrite && (region == CTRL)
                        && (offset == ctrlStartOff) && pWData[0];

    always_comb begin
        case (region)
            REGS: ctrlRData = dbgData;
            CTRL: begin
                if (offset == ctrlPcOff)
                    ctrlRData = pc;
                else if (offset == ctrlStartOff)
                    ctrlRData = {{(xlen-2){1'b0}}, halted, running};
                else
                    ctrlRData = '0;
            end
            default: ctrlRData = memRData;
        endcase
    end

    ////////////////////////////////////////
    // Instruction cycle
    ////////////////////////////////////////
    always_comb begin
        nextState = state;
        case (state)
            FETCH: nextState = EXECUTE;
            EXECUTE: begin
                case (opcode)
                    OP, OPIMM:   nextState = WRITEBACK;
                    LOAD, STORE: nextState = MEMORY;
                    SYSTEM:      nextState = HALTED;
                    default:     nextState = FETCH;   // Branches and unknown opcodes
                endcase
            end
            MEMORY:    nextState = (opcode == LOAD) ? WRITEBACK : FETCH;
            WRITEBACK: nextState = FETCH;
            default:   nextState = state;
        endcase
        if (startReq)
            nextState = FETCH;
    end

    always_ff @(posedge clock) begin
        if (rst)
            state <= IDLE;
        else
            state <= nextState;
    end

    // Last cycle of a non-branch instruction moves the PC on
    assign branchStep = (state == EXECUTE) && (opcode == BRANCH);
    assign retire     = running && (state != FETCH) && (nextState == FETCH) && !branchStep;

    assign instrLoad   = (state == FETCH);
    assign pcRestart   = startReq;
    assign pcBranch    = branchStep && cond;
    assign pcAdvance   = retire || (branchStep && !cond);
    assign regWriteEn  = (state == WRITEBACK);
    assign dmemWriteEn = (state == MEMORY) && (opcode == STORE);

endmodule

//--- src/cpuTop.sv
`timescale 1ns/10ps

module cpuTop #(
    parameter int imemWords = 256,
    parameter int dmemWords = 256
) (
    input  logic                       clock,
    input  logic                       rst,
    input  logic                       pSel,
    input  logic                       pEnable,
    input  logic                       pWrite,
    input  logic [rvPkg::apbAddrW-1:0] pAddr,
    input  logic [rvPkg::xlen-1:0]     pWData,
    output logic [rvPkg::xlen-1:0]     pRData,
    output logic                       pReady
);
    import rvPkg::*;

    cpuStateE              state;
    opcodeE                opcode;
    aluOpE                 aluOp;
    logic [xlen-1:0]       imm;
    logic                  useImm;
    logic [regAddrW-1:0]   rs1;
    logic [regAddrW-1:0]   rs2;
    logic [regAddrW-1:0]   rd;
    logic [xlen-1:0]       pc;
    logic                  cond;
    logic [xlen-1:0]       aluResult;
    logic [xlen-1:0]       opB;
    logic [xlen-1:0]       rData1;
    logic [xlen-1:0]       rData2;
    logic [xlen-1:0]       dbgData;
    logic [xlen-1:0]       wData;
    logic [xlen-1:0]       instrOut;
    logic [xlen-1:0]       dRData;
    logic [xlen-1:0]       memRData;
    logic                  instrLoad;
    logic                  pcRestart;
    logic                  pcAdvance;
    logic                  pcBranch;
    logic                  regWriteEn;
    logic                  dmemWriteEn;
    logic                  apbOwnsMem;

    // Operand and write-back selects
    assign opB   = useImm ? imm : rData2;
    assign wData = (opcode == LOAD) ? dRData : aluResult;

    ////////////////////////////////////////
    // Control
    ////////////////////////////////////////
    cycleSequencer u_seq (
        .clock       (clock),
        .rst         (rst),
        .pSel        (pSel),
        .pEnable     (pEnable),
        .pWrite      (pWrite),
        .pAddr       (pAddr),
        .pWData      (pWData),
        .opcode      (opcode),
        .pc          (pc),
        .cond        (cond),
        .memRData    (memRData),
        .dbgData     (dbgData),
        .pReady      (pReady),
        .ctrlRData   (pRData),
        .instrLoad   (instrLoad),
        .pcRestart   (pcRestart),
        .pcAdvance   (pcAdvance),
        .pcBranch    (pcBranch),
        .regWriteEn  (regWriteEn),
        .dmemWriteEn (dmemWriteEn),
        .apbOwnsMem  (apbOwnsMem),
        .state       (state)
    );

    programCounter #(.imemWords(imemWords)) u_pc (
        .clock     (clock),
        .rst       (rst),
        .pcRestart (pcRestart),
        .pcAdvance (pcAdvance),
        .pcBranch  (pcBranch),
        .cond      (cond),
        .imm       (imm),
        .pc        (pc)
    );

    ////////////////////////////////////////
    // Datapath
    ////////////////////////////////////////
    instrDecoder u_dec (
        .clock     (clock),
        .rst       (rst),
        .instrLoad (instrLoad),
        .instrIn   (instrOut),
        .opcode    (opcode),
        .aluOp     (aluOp),
        .imm       (imm),
        .useImm    (useImm),
        .rs1       (rs1),
        .rs2       (rs2),
        .rd        (rd)
    );

    aluUnit u_alu (
        .aluOp     (aluOp),
        .opA       (rData1),
        .opB       (opB),
        .aluResult (aluResult),
        .cond      (cond)
    );

    regFile u_regs (
        .clock      (clock),
        .regWriteEn (regWriteEn),
        .rs1        (rs1),
        .rs2        (rs2),
        .rd         (rd),
        .wData      (wData),
        .dbgAddr    (pAddr[regAddrW+1:2]),
        .rData1     (rData1),
        .rData2     (rData2),
        .dbgData    (dbgData)
    );

    memSystem #(
        .imemWords (imemWords),
        .dmemWords (dmemWords)
    ) u_mem (
        .clock       (clock),
        .apbOwnsMem  (apbOwnsMem),
        .pWrite      (pWrite),
        .pSel        (pSel),
        .pEnable     (pEnable),
        .pAddr       (pAddr),
        .pWData      (pWData),
        .pc          (pc),
        .instrLoad   (instrLoad),
        .dmemWriteEn (dmemWriteEn),
        .dAddr       (aluResult),
        .dWData      (rData2),
        .instrOut    (instrOut),
        .dRData      (dRData),
        .memRData    (memRData)
    );

endmodule

//--- tb/cpuTop_sva.sv
`timescale 1ns/10ps

module cpuTopSva (
    input logic                       clock,
    input logic                       rst,
    input logic                       pSel,
    input logic                       pEnable,
    input logic                       pReady,
    input logic [rvPkg::apbAddrW-1:0] pAddr,
    input logic [rvPkg::xlen-1:0]     pWData,
    input logic                       regWriteEn,
    input logic                       dmemWriteEn,
    input rvPkg::cpuStateE            state
);
    import rvPkg::*;

    // Held transfer keeps its address and data
    stableInWait: assert property (@(posedge clock) disable iff (rst)
        (pSel && pEnable && !pReady) |=> ($stable(pAddr) && $stable(pWData)))
        else $error("APB address or write data changed during a wait state");

    noWriteWhenStopped: assert property (@(posedge clock) disable iff (rst)
        (state == IDLE || state == HALTED) |-> !(regWriteEn || dmemWriteEn))
        else $error("Register or DMEM write enable high while the core is stopped");

    enableNeedsSelect: assert property (@(posedge clock) disable iff (rst)
        $rose(pEnable) |-> pSel)
        else $error("pEnable rose without pSel");

endmodule

bind cpuTop cpuTopSva u_sva (
    .clock       (clock),
    .rst         (rst),
    .pSel        (pSel),
    .pEnable     (pEnable),
    .pReady      (pReady),
    .pAddr       (pAddr),
    .pWData      (pWData),
    .regWriteEn  (regWriteEn),
    .dmemWriteEn (dmemWriteEn),
    .state       (state)
);

//--- tb/cpuTb.sv
`timescale 1ns/10ps

module cpuTb;
    import rvPkg::*;

    localparam int numProgs = 8;
    localparam int progLen  = 24;
    localparam int dWords   = 16;   // DMEM words touched by programs
    localparam int accessPerProg = 2 * progLen + 4 * dWords + 32 + 8;
    localparam int cyclesPerProg = progLen * 4 + 3 * accessPerProg;
    localparam int timeoutNs = (numProgs * cyclesPerProg + 3 * 32 + 100) * 10;

    localparam logic [15:0] imemBase = 16'h0000;
    localparam logic [15:0] dmemBase = 16'h1000;
    localparam logic [15:0] regsBase = 16'h2000;
    localparam logic [15:0] ctrlBase = 16'h3000;

    // Instruction kinds of the random generator
    localparam int kAdd = 0, kSub = 1, kAnd = 2, kOr = 3, kSll = 4, kSrl = 5, kSra = 6;
    localparam int kAddi = 7, kAndi = 8, kSlli = 9, kSrli = 10, kLw = 11, kSw = 12;
    localparam int kBeq = 13, kBne = 14, kSys = 15;

    logic        clock;
    logic        rst;
    logic        pSel;
    logic        pEnable;
    logic        pWrite;
    logic [15:0] pAddr;
    logic [31:0] pWData;
    logic [31:0] pRData;
    logic        pReady;

    logic [31:0] seed = 32'd61;
    int unsigned kind [progLen];
    logic [4:0]  rdA  [progLen];
    logic [4:0]  rs1A [progLen];
    logic [4:0]  rs2A [progLen];
    logic [31:0] immA [progLen];
    logic [31:0] word [progLen];
    logic [31:0] mReg [32];
    logic [31:0] mMem [dWords];

    cpuTop u_dut (
        .clock   (clock),
        .rst     (rst),
        .pSel    (pSel),
        .pEnable (pEnable),
        .pWrite  (pWrite),
        .pAddr   (pAddr),
        .pWData  (pWData),
        .pRData  (pRData),
        .pReady  (pReady)
    );

    initial begin
        clock = 1'b0;
        forever #5 clock = ~clock;
    end

    initial begin
        #(timeoutNs);
        $display("Timeout: the core did not halt or the APB port stopped responding");
        $display("sim failed");
        $fatal(1, "watchdog expired");
    end

    ////////////////////////////////////////
    // Helpers
    ////////////////////////////////////////
    function automatic int unsigned randBelow(input int unsigned n);
        seed = seed * 32'd1103515245 + 32'd12345;
        return (seed >> 16) % n;
    endfunction

    function automatic logic [31:0] randWord();
        logic [15:0] hi;
        logic [15:0] lo;
        hi = 16'(randBelow(65536));
        lo = 16'(randBelow(65536));
        return {hi, lo};
    endfunction

    task automatic checkEq(input logic [31:0] got, input logic [31:0] exp, input string msg);
        if (got !== exp) begin
            $display("MISMATCH at %0t ns: %s got %08h expected %08h", $time, msg, got, exp);
            $display("sim failed");
            $fatal(1, "check failed");
        end
    endtask

    // One APB transfer, inputs change on the falling edge only
    task automatic apbXfer(input logic wr, input logic [15:0] addr, input logic [31:0] wdata,
                           output logic [31:0] rdata, output int waits);
        @(negedge clock);
        pSel    = 1'b1;
        pEnable = 1'b0;
        pWrite  = wr;
        pAddr   = addr;
        pWData  = wdata;
        @(negedge clock);
        pEnable = 1'b1;
        waits   = 0;
        while (!pReady) begin
            waits++;
            @(negedge clock);
        end
        rdata = pRData;   // Transfer completes on the next rising edge
        @(negedge clock);
        pSel    = 1'b0;
        pEnable = 1'b0;
    endtask

    task automatic writeWord(input logic [15:0] addr, input logic [31:0] data);
        logic [31:0] ignored;
        int          waits;
        apbXfer(1'b1, addr, data, ignored, waits);
    endtask

    task automatic readWord(input logic [15:0] addr, output logic [31:0] data);
        int waits;
        apbXfer(1'b0, addr, 32'd0, data, waits);
    endtask

    function automatic logic [31:0] encode(input int unsigned k, input logic [4:0] rd,
                                           input logic [4:0] r1, input logic [4:0] r2,
                                           input logic [11:0] im);
        case (k)
            kAdd:    return {7'h00, r2, r1, 3'd0, rd, OP};
            kSub:    return {7'h20, r2, r1, 3'd0, rd, OP};
            kAnd:    return {7'h00, r2, r1, 3'd7, rd, OP};
            kOr:     return {7'h00, r2, r1, 3'd6, rd, OP};
            kSll:    return {7'h00, r2, r1, 3'd1, rd, OP};
            kSrl:    return {7'h00, r2, r1, 3'd5, rd, OP};
            kSra:    return {7'h20, r2, r1, 3'd5, rd, OP};
            kAddi:   return {im, r1, 3'd0, rd, OPIMM};
            kAndi:   return {im, r1, 3'd7, rd, OPIMM};
            kSlli:   return {7'h00, im[4:0], r1, 3'd1, rd, OPIMM};
            kSrli:   return {7'h00, im[4:0], r1, 3'd5, rd, OPIMM};
            kLw:     return {im, 5'd0, 3'd2, rd, LOAD};
            kSw:     return {im[11:5], r2, 5'd0, 3'd2, im[4:0], STORE};
            kBeq:    return {7'h00, r2, r1, 3'd0, 5'b01000, BRANCH};   // Offset +8
            kBne:    return {7'h00, r2, r1, 3'd1, 5'b01000, BRANCH};
            default: return {25'd0, SYSTEM};
        endcase
    endfunction

    ////////////////////////////////////////
    // Program generator and model
    ////////////////////////////////////////
    task automatic buildProgram();
        int unsigned k;
        logic [4:0]  rdx;
        logic [4:0]  r1;
        logic [4:0]  r2;
        logic [11:0] im;
        for (int i = 0; i < progLen; i++) begin
            k   = randBelow(15);
            rdx = 5'(randBelow(8));
            r1  = 5'(randBelow(8));
            r2  = 5'(randBelow(8));
            im  = 12'(randBelow(4096));
            if (i < 7) begin   // Preamble sets x1..x7
                k   = kAddi;
                rdx = 5'(i + 1);
                r1  = 5'd0;
            end
            if (k >= kBeq && i > progLen - 3)
                k = kAdd;   // Branch target must stay on or before SYSTEM
            if (i == progLen - 1)
                k = kSys;
            case (k)
                kSlli, kSrli: im = {7'd0, im[4:0]};
                kLw, kSw: begin
                    im = 12'(4 * randBelow(dWords));
                    r1 = 5'd0;
                end
                kBeq, kBne: im = 12'd8;
                default: ;
            endcase
            kind[i] = k;
            rdA[i]  = rdx;
            rs1A[i] = r1;
            rs2A[i] = r2;
            immA[i] = {{20{im[11]}}, im};
            word[i] = encode(k, rdx, r1, r2, im);
        end
    endtask

    task automatic runModel(output logic [31:0] haltPc);
        int          i;
        logic [31:0] a;
        logic [31:0] b;
        logic [31:0] addr;
        logic [31:0] res;
        i = 0;
        while (kind[i] != kSys) begin
            a    = mReg[rs1A[i]];
            b    = mReg[rs2A[i]];
            addr = a + immA[i];
            res  = 32'd0;
            case (kind[i])
                kAdd:  res = a + b;
                kSub:  res = a - b;
                kAnd:  res = a & b;
                kOr:   res = a | b;
                kSll:  res = a << b[4:0];
                kSrl:  res = a >> b[4:0];
                kSra:  res = $signed(a) >>> b[4:0];
                kAddi: res = a + immA[i];
                kAndi: res = a & immA[i];
                kSlli: res = a << immA[i][4:0];
                kSrli: res = a >> immA[i][4:0];
                kLw:   res = mMem[addr[5:2]];
                kSw:   mMem[addr[5:2]] = b;
                default: ;
            endcase
            if (kind[i] == kBeq || kind[i] == kBne) begin
                if ((a == b) == (kind[i] == kBeq))
                    i = i + 2;   // Taken
                else
                    i = i + 1;
            end else begin
                if (kind[i] != kSw && rdA[i] != 5'd0)
                    mReg[rdA[i]] = res;
                i = i + 1;
            end
        end
        haltPc = 32'(i * 4);
    endtask

    ////////////////////////////////////////
    // Main sequence
    ////////////////////////////////////////
    initial begin
        logic [31:0] rdata;
        logic [31:0] haltPc;
        int          waits;
        int unsigned probe;
        pSel    = 1'b0;
        pEnable = 1'b0;
        pWrite  = 1'b0;
        pAddr   = 16'd0;
        pWData  = 32'd0;
        rst     = 1'b1;
        repeat (2) @(posedge clock);
        @(negedge clock);
        rst = 1'b0;

        // x8..x31 are never written, so they keep what they hold now
        for (int r = 0; r < 32; r++)
            readWord(regsBase + 16'(4 * r), mReg[r]);
        checkEq(mReg[0], 32'd0, "REGS x0");

        for (int p = 0; p < numProgs; p++) begin
            buildProgram();
            for (int i = 0; i < progLen; i++)
                writeWord(imemBase + 16'(4 * i), word[i]);
            for (int w = 0; w < dWords; w++) begin
                mMem[w] = randWord();
                writeWord(dmemBase + 16'(4 * w), mMem[w]);
            end
            for (int i = 0; i < progLen; i++) begin
                readWord(imemBase + 16'(4 * i), rdata);
                checkEq(rdata, word[i], "IMEM readback");
            end
            for (int w = 0; w < dWords; w++) begin
                readWord(dmemBase + 16'(4 * w), rdata);
                checkEq(rdata, mMem[w], "DMEM readback");
            end
            runModel(haltPc);

            writeWord(ctrlBase, 32'd1);
            apbXfer(1'b0, ctrlBase, 32'd0, rdata, waits);
            checkEq(rdata, 32'd1, "status after start");
            checkEq(32'(waits), 32'd0, "wait states on CTRL read during run");
            if (p % 2 == 0) begin
                do begin
                    readWord(ctrlBase, rdata);
                end while (rdata[1] == 1'b0);
            end else begin
                probe = randBelow(dWords);
                apbXfer(1'b0, dmemBase + 16'(4 * probe), 32'd0, rdata, waits);
                checkEq(rdata, mMem[probe], "DMEM read held during run");
                checkEq((waits == 0) ? 32'd0 : 32'd1, 32'd1, "DMEM read was held off");
            end
            readWord(ctrlBase, rdata);
            checkEq(rdata, 32'd2, "status after halt");
            readWord(ctrlBase + 16'h0004, rdata);
            checkEq(rdata, haltPc, "PC at halt");

            for (int r = 0; r < 32; r++) begin
                readWord(regsBase + 16'(4 * r), rdata);
                checkEq(rdata, mReg[r], $sformatf("program %0d register x%0d", p, r));
            end
            for (int w = 0; w < dWords; w++) begin
                readWord(dmemBase + 16'(4 * w), rdata);
                checkEq(rdata, mMem[w], $sformatf("program %0d DMEM word %0d", p, w));
            end
        end

        $display("sim passed");
        $finish;
    end

endmodule

//--- rvCore.f
src/rvPkg.sv
src/aluUnit.sv
src/regFile.sv
src/instrDecoder.sv
src/programCounter.sv
src/memSystem.sv
src/cycleSequencer.sv
src/cpuTop.sv
tb/cpuTop_sva.sv
tb/cpuTb.sv

//--- run.sh
#!/bin/sh
# Compile and run the rvCore testbench with Verilator

cd "$(dirname "$0")" || exit 1

rm -rf obj_dir
verilator --binary --timing --assert --top-module cpuTb -f rvCore.f -o cpuSim
if [ $? -ne 0 ]; then
    echo "Verilator build failed"
    exit 1
fi

./obj_dir/cpuSim > sim.log 2>&1
runStatus=$?
cat sim.log

if grep -q "sim failed" sim.log; then
    exit 1
fi
if [ $runStatus -ne 0 ]; then
    echo "Simulation exited with status $runStatus"
    exit 1
fi
exit 0
